/* build.f */
rtl/alu_pkg.sv
rtl/alu_core.sv
rtl/seq_multiplier.sv
rtl/seq_divider.sv
rtl/writeback_arbiter.sv
rtl/alu_unit_top.sv
verification/alu_unit_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = alu_unit_tb
LINT_TOP   = alu_unit_top
FILELIST   = build.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/alu_unit_tb.sv */
`timescale 1ns/1ps

module alu_unit_tb;
    import alu_pkg::*;

    localparam int table_len    = 20;
    localparam int random_count = 40;
    localparam int timeout_ns   = (table_len + random_count) * 40 * 100;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    start;
    logic [opcode_width-1:0] opcode;
    logic [word_width-1:0]   a;
    logic [word_width-1:0]   b;
    logic                    ready;
    logic                    done;
    logic [opcode_width-1:0] result_op;
    logic [word_width-1:0]   hi;
    logic [word_width-1:0]   lo;

    logic [68:0] alu_q[$];            // {opcode, hi, lo} per accepted issue
    logic [68:0] mul_q[$];
    logic [68:0] div_q[$];
    logic [31:0] lfsr_state = 32'd92;
    int          pass_count = 0;
    int          fail_count = 0;

    // Columns are opcode, a, b, expected hi and expected lo
    logic [132:0] stim_table [table_len] = '{
        {op_add,  32'h7FFFFFFF, 32'h00000001, 32'h00000001, 32'h80000000},
        {op_add,  32'hFFFFFFFF, 32'h00000002, 32'h00000000, 32'h00000001},
        {op_sub,  32'h00000003, 32'h0000000A, 32'h00000000, 32'hFFFFFFF9},
        {op_shr,  32'h80000000, 32'h00000004, 32'h00000000, 32'h08000000},
        {op_shl,  32'h00000001, 32'h0000001F, 32'h00000000, 32'h80000000},
        {op_shra, 32'h80000000, 32'h00000004, 32'h00000000, 32'hF8000000},
        {op_ror,  32'h12345678, 32'h00000000, 32'h00000000, 32'h12345678},
        {op_ror,  32'h12345678, 32'h0000001F, 32'h00000000, 32'h2468ACF0},
        {op_rol,  32'h80000001, 32'h0000001F, 32'h00000000, 32'hC0000000},
        {op_and,  32'hF0F0F0F0, 32'hFF00FF00, 32'h00000000, 32'hF000F000},
        {op_or,   32'hF0F0F0F0, 32'hFF00FF00, 32'h00000000, 32'hFFF0FFF0},
        {op_xor,  32'hF0F0F0F0, 32'hFF00FF00, 32'h00000000, 32'h0FF00FF0},
        {op_nor,  32'hF0F0F0F0, 32'hFF00FF00, 32'h00000000, 32'h000F000F},
        {op_neg,  32'h00000001, 32'h00000000, 32'h00000000, 32'hFFFFFFFF},
        {op_not,  32'h0000FFFF, 32'h00000000, 32'h00000000, 32'hFFFF0000},
        {5'd0,    32'h00000005, 32'h00000005, 32'h00000000, 32'h00000000},
        {op_mul,  32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFE, 32'h00000001},
        {op_mul,  32'h00000001, 32'hDEADBEEF, 32'h00000000, 32'hDEADBEEF},
        {op_div,  32'h00000064, 32'h00000007, 32'h00000002, 32'h0000000E},
        {op_div,  32'h12345678, 32'h00000000, 32'h12345678, 32'hFFFFFFFF}
    };

    alu_unit_top dut0 (
        .clk(clk), .reset(reset), .start(start), .opcode(opcode), .a(a), .b(b),
        .ready(ready), .done(done), .result_op(result_op), .hi(hi), .lo(lo)
    );

    always #50 clk = ~clk;

    initial begin
        #(timeout_ns);
        $display("Watchdog expired after %0d ns with work still outstanding", timeout_ns);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // Galois step with taps 32 22 2 1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Expected {hi, lo} for add, mul and div
    function automatic logic [63:0] reference_result(input logic [4:0] op,
                                                     input logic [31:0] x,
                                                     input logic [31:0] y);
        logic [63:0] r;
        r = '0;
        if (op == op_add) begin
            r[31:0]  = x + y;
            r[63:32] = r[31] ? 32'd1 : 32'd0;
        end else if (op == op_mul) begin
            r = {32'd0, x} * {32'd0, y};
        end else if (op == op_div) begin
            r = (y == 32'd0) ? {x, 32'hFFFFFFFF} : {x % y, x / y};
        end
        return r;
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
        $display("[FAIL] t=%0d ns: %s expected %h, got %h", $time, name, want, got);
    endtask

    task automatic finish_test(input int bad, input string what);
        if (bad == 0) begin
            $display("[ok] t=%0d ns: %s", $time, what);
            pass_count++;
        end else begin
            $display("Test failed t=%0d ns: %s", $time, what);
            fail_count++;
        end
    endtask

    task automatic check_result();
        logic [68:0] want;
        int          bad;
        bad = 0;
        if (result_op == op_div && div_q.size() != 0) begin
            want = div_q.pop_front();
        end else if (result_op == op_mul && mul_q.size() != 0) begin
            want = mul_q.pop_front();
        end else if (result_op != op_div && result_op != op_mul && alu_q.size() != 0) begin
            want = alu_q.pop_front();
        end else begin
            $display("ERROR t=%0d ns: done with empty queue for opcode %0d", $time, result_op);
            fail_count++;
            return;
        end
        if (result_op !== want[68:64]) begin
            show_mismatch("result_op", 32'(want[68:64]), 32'(result_op));
            bad++;
        end
        if (hi !== want[63:32]) begin
            show_mismatch("hi", want[63:32], hi);
            bad++;
        end
        if (lo !== want[31:0]) begin
            show_mismatch("lo", want[31:0], lo);
            bad++;
        end
        finish_test(bad, $sformatf("result opcode %0d hi %h lo %h", result_op, hi, lo));
    endtask

    always @(negedge clk) begin
        if (!reset && done) check_result();
    end

    // Hold start until ready, then queue the expectation for the selected unit
    task automatic issue(input logic [4:0] op, input logic [31:0] x, input logic [31:0] y,
                         input logic [63:0] expect_r);
        @(negedge clk);
        start  = 1'b1;
        opcode = op;
        a      = x;
        b      = y;
        #1;
        while (!ready) begin
            @(negedge clk);
            #1;
        end
        if (op == op_div) div_q.push_back({op, expect_r});
        else if (op == op_mul) mul_q.push_back({op, expect_r});
        else alu_q.push_back({op, expect_r});
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic check_latency(input logic [4:0] op, input logic [31:0] x,
                                 input logic [31:0] y, input int cycles);
        int n;
        n = 0;
        issue(op, x, y, reference_result(op, x, y));
        while (!done) begin
            @(negedge clk);
            n++;
        end
        if (n != cycles) begin
            $display("ERROR t=%0d ns: done came %0d cycles after acceptance, expected %0d",
                     $time, n, cycles);
        end
        finish_test(n != cycles, $sformatf("opcode %0d done after %0d cycles", op, n));
    endtask

    task automatic check_ready_all();
        int bad;
        bad = 0;
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            opcode = 5'(i);
            #1;
            if (ready !== 1'b1) begin
                show_mismatch("ready", 32'd1, 32'(ready));
                bad++;
            end
            if (done !== 1'b0) begin
                show_mismatch("done", 32'd0, 32'(done));
                bad++;
            end
        end
        finish_test(bad, "ready high and done low for every opcode after reset");
    endtask

    task automatic drain();
        while (alu_q.size() + mul_q.size() + div_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        logic [132:0] row;
        logic [31:0]  sel;
        logic [4:0]   op;
        logic [31:0]  x;
        logic [31:0]  y;
        int           bad;
        reset  = 1'b1;
        start  = 1'b0;
        opcode = '0;
        a      = '0;
        b      = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        check_ready_all();
        check_latency(op_add, 32'h00000003, 32'h00000004, 2);
        check_latency(op_mul, 32'h00000000, 32'hFFFFFFFF, 34);

        for (int i = 0; i < table_len; i++) begin
            row = stim_table[i];
            issue(row[132:128], row[127:96], row[95:64], row[63:0]);
        end
        drain();

        issue(op_div, 32'd1000, 32'd3, reference_result(op_div, 32'd1000, 32'd3));
        issue(op_sub, 32'd9, 32'd4, 64'd5);
        issue(op_xor, 32'hAAAA5555, 32'hFFFF0000, {32'd0, 32'h55555555});
        issue(op_shl, 32'h00000003, 32'd4, 64'h30);
        @(negedge clk);
        opcode = op_div; // Second divide must wait for the first
        #1;
        bad = 0;
        if (ready !== 1'b0) begin
            show_mismatch("ready", 32'd0, 32'(ready));
            bad++;
        end
        while (alu_q.size() != 0) begin
            @(negedge clk);
        end
        if (div_q.size() != 1) begin
            $display("ERROR t=%0d ns: divide finished before the single-cycle results", $time);
            bad++;
        end
        finish_test(bad, "single-cycle results overtake a running divide");

        // Divide, multiply and a stream of adds finish on top of each other
        issue(op_div, 32'hFFFFFFFF, 32'd16, reference_result(op_div, 32'hFFFFFFFF, 32'd16));
        issue(op_mul, 32'h00010001, 32'hFFFFFFFF,
              reference_result(op_mul, 32'h00010001, 32'hFFFFFFFF));
        for (int i = 0; i < 12; i++) begin
            issue(op_add, 32'(i), 32'h7FFFFFFF, reference_result(op_add, 32'(i), 32'h7FFFFFFF));
        end
        drain();

        for (int i = 0; i < random_count; i++) begin
            sel = take_bits(2);
            op  = (sel == 32'd1) ? op_mul : (sel == 32'd2) ? op_div : op_add;
            x   = take_bits(32);
            y   = (op == op_div) ? take_bits(16) : take_bits(32);
            issue(op, x, y, reference_result(op, x, y));
        end
        drain();
        repeat (5) @(negedge clk);

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* rtl/alu_unit_top.sv */
`timescale 1ns/1ps

module alu_unit_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  logic [alu_pkg::opcode_width-1:0] opcode,
    input  logic [alu_pkg::word_width-1:0]   a,
    input  logic [alu_pkg::word_width-1:0]   b,
    output logic                             ready,
    output logic                             done,
    output logic [alu_pkg::opcode_width-1:0] result_op,
    output logic [alu_pkg::word_width-1:0]   hi,
    output logic [alu_pkg::word_width-1:0]   lo
);
    import alu_pkg::*;

    logic                    is_mul;
    logic                    is_div;
    logic                    accept;
    logic                    alu_idle, alu_valid, alu_grant;
    logic                    mul_idle, mul_valid, mul_grant;
    logic                    div_idle, div_valid, div_grant;
    logic [opcode_width-1:0] alu_op;
    logic [word_width-1:0]   alu_hi, alu_lo;
    logic [word_width-1:0]   mul_hi, mul_lo;
    logic [word_width-1:0]   div_hi, div_lo;

    assign is_mul = (opcode == op_mul);
    assign is_div = (opcode == op_div);
    assign ready  = is_mul ? mul_idle : is_div ? div_idle : alu_idle; // Illegal ops go to alu_core
    assign accept = start & ready;

    alu_core u_alu (
        .clk(clk), .reset(reset), .start(accept & ~is_mul & ~is_div),
        .opcode(opcode), .a(a), .b(b), .grant(alu_grant),
        .idle(alu_idle), .valid(alu_valid), .result_op(alu_op), .hi(alu_hi), .lo(alu_lo)
    );

    seq_multiplier u_mul (
        .clk(clk), .reset(reset), .start(accept & is_mul), .a(a), .b(b), .grant(mul_grant),
        .idle(mul_idle), .valid(mul_valid), .hi(mul_hi), .lo(mul_lo)
    );

    seq_divider u_div (
        .clk(clk), .reset(reset), .start(accept & is_div), .a(a), .b(b), .grant(div_grant),
        .idle(div_idle), .valid(div_valid), .hi(div_hi), .lo(div_lo)
    );

    writeback_arbiter u_arb (
        .clk(clk), .reset(reset),
        .alu_valid(alu_valid), .alu_op(alu_op), .alu_hi(alu_hi), .alu_lo(alu_lo),
        .mul_valid(mul_valid), .mul_hi(mul_hi), .mul_lo(mul_lo),
        .div_valid(div_valid), .div_hi(div_hi), .div_lo(div_lo),
        .alu_grant(alu_grant), .mul_grant(mul_grant), .div_grant(div_grant),
        .done(done), .result_op(result_op), .hi(hi), .lo(lo)
    );

endmodule

/* rtl/writeback_arbiter.sv */
`timescale 1ns/1ps

module writeback_arbiter (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             alu_valid,
    input  logic [alu_pkg::opcode_width-1:0] alu_op,
    input  logic [alu_pkg::word_width-1:0]   alu_hi,
    input  logic [alu_pkg::word_width-1:0]   alu_lo,
    input  logic                             mul_valid,
    input  logic [alu_pkg::word_width-1:0]   mul_hi,
    input  logic [alu_pkg::word_width-1:0]   mul_lo,
    input  logic                             div_valid,
    input  logic [alu_pkg::word_width-1:0]   div_hi,
    input  logic [alu_pkg::word_width-1:0]   div_lo,
    output logic                             alu_grant,
    output logic                             mul_grant,
    output logic                             div_grant,
    output logic                             done,
    output logic [alu_pkg::opcode_width-1:0] result_op,
    output logic [alu_pkg::word_width-1:0]   hi,
    output logic [alu_pkg::word_width-1:0]   lo
);
    import alu_pkg::*;

    logic div_req;
    logic mul_req;
    logic alu_req;

    // A unit granted last cycle still shows valid while it drops it
    assign div_req = div_valid & ~div_grant;
    assign mul_req = mul_valid & ~mul_grant;
    assign alu_req = alu_valid & ~alu_grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_grant <= 1'b0;
            mul_grant <= 1'b0;
            alu_grant <= 1'b0;
            done      <= 1'b0;
        end else begin
            div_grant <= div_req;                       // Divider first
            mul_grant <= mul_req & ~div_req;
            alu_grant <= alu_req & ~div_req & ~mul_req;
            done      <= div_grant | mul_grant | alu_grant;
        end
    end

    // Granted unit holds its data through the grant cycle
    always_ff @(posedge clk) begin
        if (div_grant) begin
            result_op <= op_div;
            hi        <= div_hi;
            lo        <= div_lo;
        end else if (mul_grant) begin
            result_op <= op_mul;
            hi        <= mul_hi;
            lo        <= mul_lo;
        end else if (alu_grant) begin
            result_op <= alu_op;
            hi        <= alu_hi;
            lo        <= alu_lo;
        end
    end

    // A unit still holds valid in the cycle it sees its grant
    a_grant_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
            (!div_grant || div_valid) && (!mul_grant || mul_valid) && (!alu_grant || alu_valid)
    );

endmodule

/* rtl/seq_divider.sv */
`timescale 1ns/1ps

module seq_divider (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  logic [alu_pkg::word_width-1:0] a,
    input  logic [alu_pkg::word_width-1:0] b,
    input  logic                           grant,
    output logic                           idle,
    output logic                           valid,
    output logic [alu_pkg::word_width-1:0] hi,
    output logic [alu_pkg::word_width-1:0] lo
);
    import alu_pkg::*;

    logic                  busy;
    logic [step_width-1:0] count;
    logic [word_width-1:0] divisor;
    logic [word_width-1:0] rem;
    logic [word_width-1:0] quo;
    logic [word_width+1:0] diff;   // Trial subtraction with borrow bit on top

    assign diff = {1'b0, rem, quo[word_width-1]} - {2'b00, divisor};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            valid <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (count == step_width'(mul_div_steps - 1)) begin
                busy  <= 1'b0;
                valid <= 1'b1;
            end
        end else if (grant) begin
            valid <= 1'b0;
        end
    end

    // With a zero divisor every trial succeeds, so the quotient fills with
    // ones and the dividend shifts whole into the remainder
    always_ff @(posedge clk) begin
        if (start) begin
            divisor <= b;
            rem     <= '0;
            quo     <= a;
        end else if (busy) begin
            if (!diff[word_width+1]) begin
                rem <= diff[word_width-1:0];            // Keep the difference
                quo <= {quo[word_width-2:0], 1'b1};
            end else begin
                rem <= {rem[word_width-2:0], quo[word_width-1]}; // Restore
                quo <= {quo[word_width-2:0], 1'b0};
            end
        end
    end

    assign idle = ~busy & ~valid;
    assign hi   = rem;
    assign lo   = quo;

    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (reset) start |-> idle
    );

endmodule

/* rtl/seq_multiplier.sv */
`timescale 1ns/1ps

module seq_multiplier (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  logic [alu_pkg::word_width-1:0] a,
    input  logic [alu_pkg::word_width-1:0] b,
    input  logic                           grant,
    output logic                           idle,
    output logic                           valid,
    output logic [alu_pkg::word_width-1:0] hi,
    output logic [alu_pkg::word_width-1:0] lo
);
    import alu_pkg::*;

    logic                    busy;
    logic [step_width-1:0]   count;
    logic [word_width-1:0]   mcand;
    logic [result_width-1:0] prod;   // Partial product over the shifting multiplier
    logic [word_width:0]     acc;

    // Add the multiplicand when the current multiplier bit is set
    assign acc = {1'b0, prod[result_width-1:word_width]}
               + (prod[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            valid <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (count == step_width'(mul_div_steps - 1)) begin
                busy  <= 1'b0;
                valid <= 1'b1; // Product complete, hold for writeback
            end
        end else if (grant) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= a;
            prod  <= {{word_width{1'b0}}, b};
        end else if (busy) begin
            prod <= {acc, prod[word_width-1:1]};
        end
    end

    assign idle = ~busy & ~valid;
    assign hi   = prod[result_width-1:word_width];
    assign lo   = prod[word_width-1:0];

endmodule

/* rtl/alu_core.sv */
`timescale 1ns/1ps

module alu_core (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  logic [alu_pkg::opcode_width-1:0] opcode,
    input  logic [alu_pkg::word_width-1:0]   a,
    input  logic [alu_pkg::word_width-1:0]   b,
    input  logic                             grant,
    output logic                             idle,
    output logic                             valid,
    output logic [alu_pkg::opcode_width-1:0] result_op,
    output logic [alu_pkg::word_width-1:0]   hi,
    output logic [alu_pkg::word_width-1:0]   lo
);
    import alu_pkg::*;

    logic [shamt_width-1:0]  shamt;
    logic [result_width-1:0] rot_r;
    logic [result_width-1:0] rot_l;
    logic [word_width-1:0]   sum;
    logic [word_width-1:0]   res_hi;
    logic [word_width-1:0]   res_lo;

    assign shamt = b[shamt_width-1:0];
    assign sum   = a + b;
    assign rot_r = {a, a} >> shamt; // Low word is a rotated right
    assign rot_l = {a, a} << shamt; // High word is a rotated left

    always_comb begin
        res_hi = '0;
        res_lo = '0;
        case (opcode)
            op_add: begin
                res_lo = sum;
                res_hi = sum[word_width-1] ? word_width'(1) : '0; // Sign word
            end
            op_sub:  res_lo = a - b;
            op_shr:  res_lo = a >> shamt;
            op_shl:  res_lo = a << shamt;
            op_shra: res_lo = $signed(a) >>> shamt;
            op_ror:  res_lo = rot_r[word_width-1:0];
            op_rol:  res_lo = rot_l[result_width-1:word_width];
            op_and:  res_lo = a & b;
            op_or:   res_lo = a | b;
            op_neg:  res_lo = -a;
            op_xor:  res_lo = a ^ b;
            op_nor:  res_lo = ~(a | b);
            op_not:  res_lo = ~a;
            default: res_lo = '0; // Illegal opcodes and mul/div give zero
        endcase
    end

    // One-entry slot, freed once the arbiter has taken it
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (start) begin
            valid <= 1'b1;
        end else if (grant) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result_op <= opcode;
            hi        <= res_hi;
            lo        <= res_lo;
        end
    end

    assign idle = ~valid;

    // Issue logic in the top must hold off while the slot waits for writeback
    a_no_accept_when_full: assert property (
        @(posedge clk) disable iff (reset) start |-> idle
    );

endmodule

/* rtl/alu_pkg.sv */
package alu_pkg;

    // Word sizes
    localparam int word_width   = 32;
    localparam int result_width = 2 * word_width; // hi:lo
    localparam int opcode_width = 5;

    // Opcode map of the teaching processor
    localparam logic [opcode_width-1:0] op_add  = 5'b00001;
    localparam logic [opcode_width-1:0] op_sub  = 5'b00010;
    localparam logic [opcode_width-1:0] op_mul  = 5'b00011;
    localparam logic [opcode_width-1:0] op_div  = 5'b00100;
    localparam logic [opcode_width-1:0] op_shr  = 5'b00101;
    localparam logic [opcode_width-1:0] op_shl  = 5'b00110;
    localparam logic [opcode_width-1:0] op_shra = 5'b00111;
    localparam logic [opcode_width-1:0] op_ror  = 5'b01000;
    localparam logic [opcode_width-1:0] op_rol  = 5'b01001;
    localparam logic [opcode_width-1:0] op_and  = 5'b01010;
    localparam logic [opcode_width-1:0] op_or   = 5'b01011;
    localparam logic [opcode_width-1:0] op_neg  = 5'b01100;
    localparam logic [opcode_width-1:0] op_xor  = 5'b01101;
    localparam logic [opcode_width-1:0] op_nor  = 5'b01110;
    localparam logic [opcode_width-1:0] op_not  = 5'b01111;

    // Shift amount field taken from b
    localparam int shamt_width = $clog2(word_width);

    // Sequential multiply and divide
    localparam int mul_div_steps = 32;
    localparam int step_width    = $clog2(mul_div_steps);

endpackage
